//--- bram_bridge/axil_bram_bridge.sv
// ==============================
// axi4-lite slave to single-port bram, one transaction at a time
// one instance per region behind the router
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

module axil_bram_bridge import mem_io_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  logic                      aw_valid_i,
  input  axil_aw_t                  aw_i,
  output logic                      aw_ready_o,

  input  logic                      w_valid_i,
  input  axil_w_t                   w_i,
  output logic                      w_ready_o,

  output logic                      b_valid_o,
  output axil_b_t                   b_o,
  input  logic                      b_ready_i,

  input  logic                      ar_valid_i,
  input  axil_ar_t                  ar_i,
  output logic                      ar_ready_o,

  output logic                      r_valid_o,
  output axil_r_t                   r_o,
  input  logic                      r_ready_i,

  output bram_req_t                 bram_o,
  input  logic [`MEM_IO_DATA_W-1:0] rdata_i
);

  localparam int ByteOffW = $clog2(`MEM_IO_STRB_W);

  bridge_state_e              state_q;
  logic                       rd_wait_q;  // read issued, data on rdata_i
  logic [`MEM_IO_BRAM_AW-1:0] addr_q;
  logic [`MEM_IO_STRB_W-1:0]  strb_q;
  logic [`MEM_IO_DATA_W-1:0]  wdata_q;
  logic [`MEM_IO_DATA_W-1:0]  rdata_q;

  logic idle;
  logic ar_fire;
  logic wr_fire;

  // ==============================
  // request acceptance
  // ==============================
  assign idle = (state_q == B_IDLE);

  // aw and w only as a pair, reads first
  assign ar_ready_o = idle && ar_valid_i;
  assign aw_ready_o = idle && !ar_valid_i && aw_valid_i && w_valid_i;
  assign w_ready_o  = aw_ready_o;

  assign ar_fire = ar_valid_i && ar_ready_o;
  assign wr_fire = aw_valid_i && w_valid_i && aw_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= B_IDLE;
      rd_wait_q <= 1'b0;
    end else begin
      case (state_q)
        B_IDLE: begin
          if (ar_fire) begin
            state_q <= B_READ;
          end else if (wr_fire) begin
            state_q <= B_WRITE;
          end
        end
        B_WRITE: state_q <= B_RESP_B;
        B_READ: begin
          rd_wait_q <= !rd_wait_q;  // issue cycle, then capture cycle
          if (rd_wait_q) begin
            state_q <= B_RESP_R;
          end
        end
        B_RESP_B: begin
          if (b_ready_i) begin
            state_q <= B_IDLE;
          end
        end
        B_RESP_R: begin
          if (r_ready_i) begin
            state_q <= B_IDLE;
          end
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  // window offset only, region test is done upstream
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      addr_q <= ar_i.addr[ByteOffW +: `MEM_IO_BRAM_AW];
    end else if (wr_fire) begin
      addr_q  <= aw_i.addr[ByteOffW +: `MEM_IO_BRAM_AW];
      strb_q  <= w_i.strb;
      wdata_q <= w_i.data;
    end
    if (state_q == B_READ && rd_wait_q) begin
      rdata_q <= rdata_i;
    end
  end

  // ==============================
  // bram port and responses
  // ==============================
  assign bram_o.en    = (state_q == B_WRITE) || (state_q == B_READ && !rd_wait_q);
  assign bram_o.we    = (state_q == B_WRITE);
  assign bram_o.addr  = addr_q;
  assign bram_o.wmask = (state_q == B_WRITE) ? strb_q : '0;
  assign bram_o.wdata = wdata_q;

  assign b_valid_o = (state_q == B_RESP_B);
  assign b_o       = '{resp: RESP_OKAY};

  assign r_valid_o = (state_q == B_RESP_R);  // held until r_ready_i
  assign r_o       = '{data: rdata_q, resp: RESP_OKAY};

endmodule

`default_nettype wire

//--- common/mem_io_defs.svh
// ==============================
// widths and address map of the memory/io wrapper
// included by the package, the rtl and the testbench
// ==============================

`ifndef MEM_IO_DEFS_SVH
`define MEM_IO_DEFS_SVH

// bus widths
`define MEM_IO_ADDR_W   32
`define MEM_IO_DATA_W   64
`define MEM_IO_STRB_W   8

// bram word address, 64 KiB per region
`define MEM_IO_BRAM_AW  13

// ==============================
// address windows, base plus offset mask
// ==============================
`define MEM_IO_MEM_BASE 32'h8000_0000
`define MEM_IO_MEM_MASK 32'h0000_FFFF
`define MEM_IO_IO_BASE  32'h8001_0000
`define MEM_IO_IO_MASK  32'h0000_003F

`endif

//--- common/mem_io_pkg.sv
// ==============================
// shared types: axi4-lite channels, bram port and state encodings
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

package mem_io_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // ==============================
  // axi4-lite channel payloads
  // ==============================
  typedef struct packed {
    logic [`MEM_IO_ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [`MEM_IO_DATA_W-1:0] data;
    logic [`MEM_IO_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`MEM_IO_ADDR_W-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [`MEM_IO_DATA_W-1:0] data;
    axil_resp_e                resp;
  } axil_r_t;

  // bram request, rdata comes back one cycle later
  typedef struct packed {
    logic                       en;
    logic                       we;
    logic [`MEM_IO_BRAM_AW-1:0] addr;  // 64-bit word address
    logic [`MEM_IO_STRB_W-1:0]  wmask;
    logic [`MEM_IO_DATA_W-1:0]  wdata;
  } bram_req_t;

  typedef enum logic [1:0] {ROUTE_MEM, ROUTE_IO, ROUTE_NONE} route_e;

  typedef enum logic [1:0] {R_IDLE, R_WAIT_BRIDGE, R_DECERR_B, R_DECERR_R} router_state_e;

  typedef enum logic [2:0] {B_IDLE, B_WRITE, B_READ, B_RESP_B, B_RESP_R} bridge_state_e;

endpackage

`default_nettype wire

//--- hw/axil_router.sv
// ==============================
// host axi4-lite port to memory and io bridges, one transaction in flight
// unmapped addresses are answered here with DECERR
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

module axil_router import mem_io_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  logic     s_aw_valid_i,
  input  axil_aw_t s_aw_i,
  output logic     s_aw_ready_o,
  input  logic     s_w_valid_i,
  input  axil_w_t  s_w_i,
  output logic     s_w_ready_o,
  output logic     s_b_valid_o,
  output axil_b_t  s_b_o,
  input  logic     s_b_ready_i,
  input  logic     s_ar_valid_i,
  input  axil_ar_t s_ar_i,
  output logic     s_ar_ready_o,
  output logic     s_r_valid_o,
  output axil_r_t  s_r_o,
  input  logic     s_r_ready_i,

  output logic     mem_aw_valid_o,
  output axil_aw_t mem_aw_o,
  input  logic     mem_aw_ready_i,
  output logic     mem_w_valid_o,
  output axil_w_t  mem_w_o,
  input  logic     mem_w_ready_i,
  input  logic     mem_b_valid_i,
  input  axil_b_t  mem_b_i,
  output logic     mem_b_ready_o,
  output logic     mem_ar_valid_o,
  output axil_ar_t mem_ar_o,
  input  logic     mem_ar_ready_i,
  input  logic     mem_r_valid_i,
  input  axil_r_t  mem_r_i,
  output logic     mem_r_ready_o,

  output logic     io_aw_valid_o,
  output axil_aw_t io_aw_o,
  input  logic     io_aw_ready_i,
  output logic     io_w_valid_o,
  output axil_w_t  io_w_o,
  input  logic     io_w_ready_i,
  input  logic     io_b_valid_i,
  input  axil_b_t  io_b_i,
  output logic     io_b_ready_o,
  output logic     io_ar_valid_o,
  output axil_ar_t io_ar_o,
  input  logic     io_ar_ready_i,
  input  logic     io_r_valid_i,
  input  axil_r_t  io_r_i,
  output logic     io_r_ready_o
);

  router_state_e state_q;
  route_e        route_q;
  logic          wr_q;    // active transaction is a write
  logic          sent_q;  // bridge has taken the request
  logic          live_q;  // low until first edge after reset
  axil_aw_t      aw_q;
  axil_w_t       w_q;
  axil_ar_t      ar_q;

  route_e ar_route;
  route_e aw_route;
  logic   idle, ar_fire, wr_fire, fwd_fire, done;
  logic   wait_mem, wait_io;

  function automatic route_e decode(input logic [`MEM_IO_ADDR_W-1:0] addr);
    route_e route;
    route = ROUTE_NONE;
    if ((addr & ~`MEM_IO_MEM_MASK) == `MEM_IO_MEM_BASE)
      route = ROUTE_MEM;
    else if ((addr & ~`MEM_IO_IO_MASK) == `MEM_IO_IO_BASE)
      route = ROUTE_IO;
    return route;
  endfunction

  assign ar_route = decode(s_ar_i.addr);
  assign aw_route = decode(s_aw_i.addr);

  // ==============================
  // host acceptance
  // ==============================
  assign idle         = (state_q == R_IDLE) && live_q;
  assign s_ar_ready_o = idle;
  assign s_aw_ready_o = idle && !s_ar_valid_i && s_w_valid_i;  // read wins
  assign s_w_ready_o  = idle && !s_ar_valid_i && s_aw_valid_i;
  assign ar_fire      = s_ar_valid_i && s_ar_ready_o;
  assign wr_fire      = s_aw_valid_i && s_aw_ready_o;

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      ar_q <= s_ar_i;
    end
    if (wr_fire) begin
      aw_q <= s_aw_i;
      w_q  <= s_w_i;
    end
  end

  // ==============================
  // forward path, one registered cycle
  // ==============================
  assign wait_mem = (state_q == R_WAIT_BRIDGE) && (route_q == ROUTE_MEM);
  assign wait_io  = (state_q == R_WAIT_BRIDGE) && (route_q == ROUTE_IO);

  assign mem_aw_valid_o = wait_mem && wr_q && !sent_q;
  assign mem_w_valid_o  = mem_aw_valid_o;
  assign mem_ar_valid_o = wait_mem && !wr_q && !sent_q;
  assign io_aw_valid_o  = wait_io && wr_q && !sent_q;
  assign io_w_valid_o   = io_aw_valid_o;
  assign io_ar_valid_o  = wait_io && !wr_q && !sent_q;

  assign mem_aw_o = aw_q;
  assign mem_w_o  = w_q;
  assign mem_ar_o = ar_q;
  assign io_aw_o  = aw_q;
  assign io_w_o   = w_q;
  assign io_ar_o  = ar_q;

  assign fwd_fire = (mem_aw_valid_o && mem_aw_ready_i && mem_w_ready_i)
                 || (mem_ar_valid_o && mem_ar_ready_i)
                 || (io_aw_valid_o && io_aw_ready_i && io_w_ready_i)
                 || (io_ar_valid_o && io_ar_ready_i);

  // ==============================
  // return path, combinational
  // ==============================
  assign s_b_valid_o = (state_q == R_DECERR_B)
                    || (wait_mem && wr_q && mem_b_valid_i)
                    || (wait_io && wr_q && io_b_valid_i);
  assign s_r_valid_o = (state_q == R_DECERR_R)
                    || (wait_mem && !wr_q && mem_r_valid_i)
                    || (wait_io && !wr_q && io_r_valid_i);

  assign s_b_o = wait_mem ? mem_b_i : wait_io ? io_b_i : '{resp: RESP_DECERR};
  assign s_r_o = wait_mem ? mem_r_i : wait_io ? io_r_i : '{data: '0, resp: RESP_DECERR};

  assign mem_b_ready_o = wait_mem && wr_q && s_b_ready_i;
  assign mem_r_ready_o = wait_mem && !wr_q && s_r_ready_i;
  assign io_b_ready_o  = wait_io && wr_q && s_b_ready_i;
  assign io_r_ready_o  = wait_io && !wr_q && s_r_ready_i;

  assign done = (s_b_valid_o && s_b_ready_i) || (s_r_valid_o && s_r_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= R_IDLE;
      route_q <= ROUTE_NONE;
      wr_q    <= 1'b0;
      sent_q  <= 1'b0;
      live_q  <= 1'b0;
    end else begin
      live_q <= 1'b1;
      case (state_q)
        R_IDLE: begin
          sent_q <= 1'b0;
          if (ar_fire) begin
            route_q <= ar_route;
            wr_q    <= 1'b0;
            state_q <= (ar_route == ROUTE_NONE) ? R_DECERR_R : R_WAIT_BRIDGE;
          end else if (wr_fire) begin
            route_q <= aw_route;
            wr_q    <= 1'b1;
            state_q <= (aw_route == ROUTE_NONE) ? R_DECERR_B : R_WAIT_BRIDGE;
          end
        end
        R_WAIT_BRIDGE: begin
          if (fwd_fire) begin
            sent_q <= 1'b1;
          end
          if (done) begin
            state_q <= R_IDLE;
          end
        end
        default: begin
          if (done) begin
            state_q <= R_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_io_wrapper.sv
// ==============================
// memory-side wrapper, host axi4-lite in, two bram ports out
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

module mem_io_wrapper import mem_io_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  logic                      s_aw_valid_i,
  input  axil_aw_t                  s_aw_i,
  output logic                      s_aw_ready_o,
  input  logic                      s_w_valid_i,
  input  axil_w_t                   s_w_i,
  output logic                      s_w_ready_o,
  output logic                      s_b_valid_o,
  output axil_b_t                   s_b_o,
  input  logic                      s_b_ready_i,
  input  logic                      s_ar_valid_i,
  input  axil_ar_t                  s_ar_i,
  output logic                      s_ar_ready_o,
  output logic                      s_r_valid_o,
  output axil_r_t                   s_r_o,
  input  logic                      s_r_ready_i,

  output bram_req_t                 mem_bram_o,
  input  logic [`MEM_IO_DATA_W-1:0] mem_rdata_i,
  output bram_req_t                 io_bram_o,
  input  logic [`MEM_IO_DATA_W-1:0] io_rdata_i
);

  // ==============================
  // router to bridge channels
  // ==============================
  logic     mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready, mem_b_valid, mem_b_ready;
  logic     mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  axil_aw_t mem_aw;
  axil_w_t  mem_w;
  axil_b_t  mem_b;
  axil_ar_t mem_ar;
  axil_r_t  mem_r;

  logic     io_aw_valid, io_aw_ready, io_w_valid, io_w_ready, io_b_valid, io_b_ready;
  logic     io_ar_valid, io_ar_ready, io_r_valid, io_r_ready;
  axil_aw_t io_aw;
  axil_w_t  io_w;
  axil_b_t  io_b;
  axil_ar_t io_ar;
  axil_r_t  io_r;

  axil_router i_router (
    .clk_i, .arst_n_i,
    .s_aw_valid_i, .s_aw_i, .s_aw_ready_o,
    .s_w_valid_i, .s_w_i, .s_w_ready_o,
    .s_b_valid_o, .s_b_o, .s_b_ready_i,
    .s_ar_valid_i, .s_ar_i, .s_ar_ready_o,
    .s_r_valid_o, .s_r_o, .s_r_ready_i,
    .mem_aw_valid_o (mem_aw_valid), .mem_aw_o (mem_aw), .mem_aw_ready_i (mem_aw_ready),
    .mem_w_valid_o  (mem_w_valid),  .mem_w_o  (mem_w),  .mem_w_ready_i  (mem_w_ready),
    .mem_b_valid_i  (mem_b_valid),  .mem_b_i  (mem_b),  .mem_b_ready_o  (mem_b_ready),
    .mem_ar_valid_o (mem_ar_valid), .mem_ar_o (mem_ar), .mem_ar_ready_i (mem_ar_ready),
    .mem_r_valid_i  (mem_r_valid),  .mem_r_i  (mem_r),  .mem_r_ready_o  (mem_r_ready),
    .io_aw_valid_o  (io_aw_valid),  .io_aw_o  (io_aw),  .io_aw_ready_i  (io_aw_ready),
    .io_w_valid_o   (io_w_valid),   .io_w_o   (io_w),   .io_w_ready_i   (io_w_ready),
    .io_b_valid_i   (io_b_valid),   .io_b_i   (io_b),   .io_b_ready_o   (io_b_ready),
    .io_ar_valid_o  (io_ar_valid),  .io_ar_o  (io_ar),  .io_ar_ready_i  (io_ar_ready),
    .io_r_valid_i   (io_r_valid),   .io_r_i   (io_r),   .io_r_ready_o   (io_r_ready)
  );

  axil_bram_bridge i_mem_bridge (
    .clk_i, .arst_n_i,
    .aw_valid_i (mem_aw_valid), .aw_i (mem_aw), .aw_ready_o (mem_aw_ready),
    .w_valid_i  (mem_w_valid),  .w_i  (mem_w),  .w_ready_o  (mem_w_ready),
    .b_valid_o  (mem_b_valid),  .b_o  (mem_b),  .b_ready_i  (mem_b_ready),
    .ar_valid_i (mem_ar_valid), .ar_i (mem_ar), .ar_ready_o (mem_ar_ready),
    .r_valid_o  (mem_r_valid),  .r_o  (mem_r),  .r_ready_i  (mem_r_ready),
    .bram_o     (mem_bram_o),
    .rdata_i    (mem_rdata_i)
  );

  axil_bram_bridge i_io_bridge (
    .clk_i, .arst_n_i,
    .aw_valid_i (io_aw_valid), .aw_i (io_aw), .aw_ready_o (io_aw_ready),
    .w_valid_i  (io_w_valid),  .w_i  (io_w),  .w_ready_o  (io_w_ready),
    .b_valid_o  (io_b_valid),  .b_o  (io_b),  .b_ready_i  (io_b_ready),
    .ar_valid_i (io_ar_valid), .ar_i (io_ar), .ar_ready_o (io_ar_ready),
    .r_valid_o  (io_r_valid),  .r_o  (io_r),  .r_ready_i  (io_r_ready),
    .bram_o     (io_bram_o),
    .rdata_i    (io_rdata_i)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the testbench with verilator, runs it and checks sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module tb_mem_io_wrapper -o tb_sim \
  > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { echo "simulation exited with an error, see sim.log"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

//--- testbench/bram_model.sv
// ==============================
// behavioral bram with one-cycle read latency and byte write mask
// memory starts with an address-dependent fill pattern
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

module bram_model import mem_io_pkg::*; #(
  parameter logic [15:0] FillTag = 16'h0000
) (
  input  logic                      clk_i,
  input  bram_req_t                 req_i,
  output logic [`MEM_IO_DATA_W-1:0] rdata_o
);

  localparam int Words = 1 << `MEM_IO_BRAM_AW;

  logic [`MEM_IO_DATA_W-1:0] mem [Words];

  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = {FillTag, 16'(i), ~16'(i), 16'(i) ^ 16'h5a5a};  // every word differs
    end
  end

  always @(posedge clk_i) begin
    if (req_i.en) begin
      if (req_i.we) begin
        for (int b = 0; b < `MEM_IO_STRB_W; b++) begin
          if (req_i.wmask[b]) begin
            mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[req_i.addr];  // valid in the next cycle
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_mem_io_wrapper.sv
// ==============================
// directed testbench for the memory/io wrapper
// host axi4-lite traffic against scoreboards of both bram regions
// ==============================

`default_nettype none

`include "mem_io_defs.svh"

module tb_mem_io_wrapper import mem_io_pkg::*; ();

  localparam int          Timeout  = 50;
  localparam int          MemWords = (`MEM_IO_MEM_MASK + 1) / 8;
  localparam int          IoWords  = (`MEM_IO_IO_MASK + 1) / 8;
  localparam logic [31:0] MemBase  = `MEM_IO_MEM_BASE;
  localparam logic [31:0] IoBase   = `MEM_IO_IO_BASE;
  localparam logic [15:0] MemTag   = 16'h3e3e;
  localparam logic [15:0] IoTag    = 16'h10c0;

  logic      clk, arst_n;
  logic      aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic      ar_valid, ar_ready, r_valid, r_ready;
  axil_aw_t  aw;
  axil_w_t   w;
  axil_b_t   b;
  axil_ar_t  ar;
  axil_r_t   r;
  bram_req_t mem_bram, io_bram;
  logic [63:0] mem_rdata, io_rdata;

  logic [63:0] mem_sb [MemWords];
  logic [63:0] io_sb [IoWords];
  int          errors;
  int          timeouts;
  int          mem_en_cnt = 0;
  int          io_en_cnt = 0;
  logic [15:0] lfsr;
  string       cur_test;

  mem_io_wrapper i_mem_io_wrapper (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .s_aw_valid_i (aw_valid),
    .s_aw_i       (aw),
    .s_aw_ready_o (aw_ready),
    .s_w_valid_i  (w_valid),
    .s_w_i        (w),
    .s_w_ready_o  (w_ready),
    .s_b_valid_o  (b_valid),
    .s_b_o        (b),
    .s_b_ready_i  (b_ready),
    .s_ar_valid_i (ar_valid),
    .s_ar_i       (ar),
    .s_ar_ready_o (ar_ready),
    .s_r_valid_o  (r_valid),
    .s_r_o        (r),
    .s_r_ready_i  (r_ready),
    .mem_bram_o   (mem_bram),
    .mem_rdata_i  (mem_rdata),
    .io_bram_o    (io_bram),
    .io_rdata_i   (io_rdata)
  );

  bram_model #(.FillTag(MemTag)) i_mem_bram (.clk_i(clk), .req_i(mem_bram), .rdata_o(mem_rdata));
  bram_model #(.FillTag(IoTag)) i_io_bram (.clk_i(clk), .req_i(io_bram), .rdata_o(io_rdata));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // bram enable pulses, sampled mid-cycle
  always @(negedge clk) begin
    if (mem_bram.en) mem_en_cnt <= mem_en_cnt + 1;
    if (io_bram.en) io_en_cnt <= io_en_cnt + 1;
  end

  // ==============================
  // reference model and random source
  // ==============================
  function automatic logic [63:0] fill_word(input logic [15:0] tag, input int idx);
    return {tag, 16'(idx), ~16'(idx), 16'(idx) ^ 16'h5a5a};
  endfunction

  function automatic route_e expect_route(input logic [31:0] addr);
    if (addr[31:16] == MemBase[31:16]) return ROUTE_MEM;  // 64 KiB window
    if (addr[31:6] == IoBase[31:6]) return ROUTE_IO;      // 64 byte window
    return ROUTE_NONE;
  endfunction

  function automatic int word_index(input logic [31:0] addr, input route_e route);
    return (route == ROUTE_IO) ? int'(addr[5:3]) : int'(addr[15:3]);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_random(input int nbits, output logic [63:0] v);
    int k;
    v = '0;
    for (k = 0; k < nbits; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAIL %s: %s expected %h actual %h", cur_test, what, expected, actual);
    errors++;
  endtask

  task automatic note_timeout(input string what);
    $display("%s: gave up after %0d cycles waiting for %s", cur_test, Timeout, what);
    errors++;
    timeouts++;
  endtask

  // ==============================
  // bus helpers, entered 1 unit after an edge
  // ==============================
  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    int n;
    n = 0;
    aw_valid = 1'b1;
    aw.addr  = addr;
    w_valid  = 1'b1;
    w        = '{data: data, strb: strb};
    #1;
    while (!(aw_ready && w_ready) && n < Timeout) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!(aw_ready && w_ready)) note_timeout("aw/w ready");
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int n;
    n = 0;
    ar_valid = 1'b1;
    ar.addr  = addr;
    #1;
    while (!ar_ready && n < Timeout) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!ar_ready) note_timeout("ar ready");
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
  endtask

  // lat counts edges from acceptance to the response transfer
  task automatic wait_response(input logic is_write, output int lat, output axil_resp_e resp,
                               output logic [63:0] data);
    lat  = 1;
    resp = RESP_SLVERR;
    data = '0;
    if (is_write) b_ready = 1'b1;
    else r_ready = 1'b1;
    #1;
    while (!(is_write ? b_valid : r_valid) && lat <= Timeout) begin
      @(posedge clk);
      #2;
      lat++;
    end
    if (!(is_write ? b_valid : r_valid)) begin
      note_timeout(is_write ? "bvalid" : "rvalid");
    end else begin
      resp = is_write ? b.resp : r.resp;
      data = is_write ? 64'd0 : r.data;
    end
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    r_ready = 1'b0;
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, output int lat);
    route_e      route;
    int          idx;
    axil_resp_e  resp;
    logic [63:0] rdata_dummy;
    route = expect_route(addr);
    idx   = word_index(addr, route);
    axil_write(addr, data, strb);
    wait_response(1'b1, lat, resp, rdata_dummy);
    if (route == ROUTE_NONE) begin
      if (resp !== RESP_DECERR) report_mismatch("write resp", 64'(RESP_DECERR), 64'(resp));
    end else begin
      if (resp !== RESP_OKAY) report_mismatch("write resp", 64'(RESP_OKAY), 64'(resp));
      if (route == ROUTE_MEM) mem_sb[idx] = merge_bytes(mem_sb[idx], data, strb);
      else io_sb[idx] = merge_bytes(io_sb[idx], data, strb);
    end
  endtask

  task automatic check_read(input logic [31:0] addr, output int lat);
    route_e      route;
    int          idx;
    axil_resp_e  resp;
    axil_resp_e  exp_resp;
    logic [63:0] data;
    logic [63:0] exp_data;
    route = expect_route(addr);
    idx   = word_index(addr, route);
    case (route)
      ROUTE_MEM: begin
        exp_data = mem_sb[idx];
        exp_resp = RESP_OKAY;
      end
      ROUTE_IO: begin
        exp_data = io_sb[idx];
        exp_resp = RESP_OKAY;
      end
      default: begin
        exp_data = '0;  // decode error carries no data
        exp_resp = RESP_DECERR;
      end
    endcase
    axil_read(addr);
    wait_response(1'b0, lat, resp, data);
    if (resp !== exp_resp) report_mismatch("read resp", 64'(exp_resp), 64'(resp));
    if (data !== exp_data) report_mismatch("read data", exp_data, data);
  endtask

  // holds ready low on a pending response while an ar probe waits
  task automatic stall_response(input logic is_write, input logic [63:0] exp_data,
                                input logic [31:0] probe_addr);
    int n;
    int k;
    n = 0;
    #1;
    while (!(is_write ? b_valid : r_valid) && n < Timeout) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!(is_write ? b_valid : r_valid)) note_timeout("a response with ready low");
    for (k = 0; k < 5; k++) begin
      @(posedge clk);
      #1;
      ar_valid = 1'b1;
      ar.addr  = probe_addr;
      #1;
      if (is_write) begin
        if (b_valid !== 1'b1) report_mismatch("held bvalid", 64'd1, 64'(b_valid));
        if (b.resp !== RESP_OKAY) report_mismatch("held bresp", 64'(RESP_OKAY), 64'(b.resp));
      end else begin
        if (r_valid !== 1'b1) report_mismatch("held rvalid", 64'd1, 64'(r_valid));
        if (r.data !== exp_data) report_mismatch("held rdata", exp_data, r.data);
        if (r.resp !== RESP_OKAY) report_mismatch("held rresp", 64'(RESP_OKAY), 64'(r.resp));
      end
      if (ar_ready !== 1'b0) report_mismatch("ar_ready while stalled", 64'd0, 64'(ar_ready));
    end
    @(posedge clk);
    #1;
    if (is_write) b_ready = 1'b1;
    else r_ready = 1'b1;
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    r_ready = 1'b0;
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic mem_rw();
    int lat;
    cur_test = "mem_rw";
    check_write(32'h8000_0000, 64'h0123_4567_89ab_cdef, 8'hff, lat);
    check_write(32'h8000_0008, 64'hfedc_ba98_7654_3210, 8'hff, lat);
    check_write(32'h8000_fff8, 64'h5555_aaaa_3333_cccc, 8'hff, lat);  // top word
    check_read(32'h8000_0000, lat);
    check_read(32'h8000_0008, lat);
    check_read(32'h8000_fff8, lat);
    check_write(32'h8000_0008, 64'h1111_2222_3333_4444, 8'h0f, lat);
    check_write(32'h8000_0000, 64'hdead_beef_cafe_f00d, 8'ha5, lat);
    check_write(32'h8000_0103, 64'h7777_6666_5555_4444, 8'h81, lat);  // merges with fill
    check_read(32'h8000_0008, lat);
    check_read(32'h8000_0000, lat);
    check_read(32'h8000_0100, lat);
  endtask

  task automatic io_rw();
    int lat;
    int m0;
    int i0;
    cur_test = "io_rw";
    m0 = mem_en_cnt;
    i0 = io_en_cnt;
    check_write(32'h8001_0008, 64'h0bad_f00d_1234_5678, 8'hff, lat);
    check_write(32'h8001_0038, 64'ha1a2_a3a4_a5a6_a7a8, 8'h3c, lat);
    check_read(32'h8001_0008, lat);
    check_read(32'h8001_0038, lat);
    check_read(32'h8001_0020, lat);
    if (io_en_cnt - i0 != 5) report_mismatch("io bram enables", 64'd5, 64'(io_en_cnt - i0));
    if (mem_en_cnt != m0) report_mismatch("mem bram enables", 64'd0, 64'(mem_en_cnt - m0));
    m0 = mem_en_cnt;
    i0 = io_en_cnt;
    check_read(32'h8000_0000, lat);
    check_write(32'h8000_0010, 64'h0f0f_0f0f_f0f0_f0f0, 8'hff, lat);
    if (mem_en_cnt - m0 != 2) report_mismatch("mem bram enables", 64'd2, 64'(mem_en_cnt - m0));
    if (io_en_cnt != i0) report_mismatch("io bram enables", 64'd0, 64'(io_en_cnt - i0));
  endtask

  task automatic decode_error();
    int lat;
    int m0;
    int i0;
    cur_test = "decode_error";
    m0 = mem_en_cnt;
    i0 = io_en_cnt;
    check_write(32'h8002_0000, 64'hbad0_bad0_bad0_bad0, 8'hff, lat);  // mem offset alias
    check_write(32'h8001_0040, 64'hbad1_bad1_bad1_bad1, 8'hff, lat);  // just past io
    check_read(32'h0000_0000, lat);
    check_read(32'hffff_fff8, lat);
    check_read(32'h7fff_fff8, lat);
    if (mem_en_cnt != m0) report_mismatch("mem bram enables", 64'd0, 64'(mem_en_cnt - m0));
    if (io_en_cnt != i0) report_mismatch("io bram enables", 64'd0, 64'(io_en_cnt - i0));
    check_read(32'h8000_0000, lat);
    check_read(32'h8001_0000, lat);
  endtask

  task automatic backpressure();
    int lat;
    cur_test = "backpressure";
    axil_read(32'h8000_0008);
    stall_response(1'b0, mem_sb[1], 32'h8000_0010);
    check_read(32'h8000_0010, lat);  // probe goes through after r
    axil_write(32'h8000_0018, 64'h4242_4242_2424_2424, 8'hff);
    mem_sb[3] = merge_bytes(mem_sb[3], 64'h4242_4242_2424_2424, 8'hff);
    stall_response(1'b1, 64'd0, 32'h8000_0018);
    check_read(32'h8000_0018, lat);
  endtask

  task automatic latency();
    int lat;
    cur_test = "latency";
    check_write(32'h8000_0020, 64'h0000_1111_2222_3333, 8'hff, lat);
    if (lat != 3) report_mismatch("mem write latency", 64'd3, 64'(lat));
    check_read(32'h8000_0020, lat);
    if (lat != 4) report_mismatch("mem read latency", 64'd4, 64'(lat));
    check_write(32'h8001_0010, 64'h4444_5555_6666_7777, 8'hff, lat);
    if (lat != 3) report_mismatch("io write latency", 64'd3, 64'(lat));
    check_read(32'h8001_0010, lat);
    if (lat != 4) report_mismatch("io read latency", 64'd4, 64'(lat));
    check_write(32'h4000_0000, 64'h8888_9999_aaaa_bbbb, 8'hff, lat);
    if (lat != 1) report_mismatch("decerr write latency", 64'd1, 64'(lat));
    check_read(32'h8001_0040, lat);
    if (lat != 1) report_mismatch("decerr read latency", 64'd1, 64'(lat));
  endtask

  task automatic random_mix();
    int          i;
    int          lat;
    logic [63:0] v;
    logic        is_rd;
    logic [31:0] addr;
    logic [7:0]  strb;
    cur_test = "random_mix";
    for (i = 0; i < 60; i++) begin
      take_random(1, v);
      is_rd = v[0];
      take_random(2, v);
      case (v[1:0])
        2'd2: begin
          take_random(3, v);
          addr = IoBase | {26'd0, v[2:0], 3'b000};
        end
        2'd3: begin
          take_random(8, v);
          addr = 32'h8001_0040 + {21'd0, v[7:0], 3'b000};  // unmapped
        end
        default: begin
          take_random(4, v);
          addr = MemBase | {25'd0, v[3:0], 3'b000};  // few words, many hits
        end
      endcase
      take_random(3, v);
      addr[2:0] = v[2:0];
      if (is_rd) begin
        check_read(addr, lat);
      end else begin
        take_random(8, v);
        strb = v[7:0];
        take_random(64, v);
        check_write(addr, v, strb, lat);
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    errors   = 0;
    timeouts = 0;
    lfsr     = 16'd84;
    cur_test = "reset";
    arst_n   = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    for (int k = 0; k < MemWords; k++) begin
      mem_sb[k] = fill_word(MemTag, k);
    end
    for (int k = 0; k < IoWords; k++) begin
      io_sb[k] = fill_word(IoTag, k);
    end
    repeat (5) @(posedge clk);
    #1;
    if ({aw_ready, w_ready, ar_ready, b_valid, r_valid, mem_bram.en, mem_bram.we,
         io_bram.en, io_bram.we} !== 9'd0) begin
      report_mismatch("outputs in reset", 64'd0, 64'({aw_ready, w_ready, ar_ready, b_valid,
                      r_valid, mem_bram.en, mem_bram.we, io_bram.en, io_bram.we}));
    end
    arst_n = 1'b1;
    @(posedge clk);
    #2;
    if (ar_ready !== 1'b1) report_mismatch("ar_ready after reset", 64'd1, 64'(ar_ready));
    @(posedge clk);
    #1;
    mem_rw();
    io_rw();
    decode_error();
    backpressure();
    latency();
    random_mix();
    $display("errors: %0d (timeouts: %0d)", errors, timeouts);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/mem_io_pkg.sv
bram_bridge/axil_bram_bridge.sv
hw/axil_router.sv
hw/mem_io_wrapper.sv
testbench/bram_model.sv
testbench/tb_mem_io_wrapper.sv
